/* design/frame_parser.sv */
/*
 * Receive side of the echo core. Frames carry no FCS and no IP options.
 * A frame that ends before its UDP length closes the payload early, and
 * the reply then carries the original length fields.
 */
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module frame_parser (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  rx_tdata,
    input  logic                        rx_tvalid,
    input  logic                        rx_tlast,
    output logic                        rx_tready,
    input  logic [47:0]                 local_mac,
    input  logic [31:0]                 local_ip,
    output logic                        hdr_push,
    output udp_echo_pkg::echo_hdr_t     hdr_item,
    input  logic                        hdr_full,
    output logic                        pay_push,
    output udp_echo_pkg::payload_beat_t pay_item,
    input  logic                        pay_full
);

    typedef enum logic [1:0] {S_HDR, S_PAY, S_DROP} state_t;

    state_t      state;
    logic [7:0]  idx;
    logic [7:0]  prev_byte;
    logic [47:0] dst_mac;
    logic [47:0] rem_mac;
    logic [31:0] dst_ip;
    logic [31:0] rem_ip;
    logic [15:0] rem_port;
    logic [15:0] udp_len;
    logic [15:0] pay_left;
    logic        fields_ok;
    logic        xfer;
    logic        hdr_end;
    logic        accept;
    logic        pay_last;

    assign xfer    = rx_tvalid && rx_tready;
    assign hdr_end = (state == S_HDR) && (idx == `UDP_ECHO_HDR_BYTES - 8'd1);
    assign accept  = fields_ok && (dst_mac == local_mac || dst_mac == {48{1'b1}}) &&
                     (dst_ip == local_ip) && (udp_len > 16'd8) && !rx_tlast;
    assign pay_last = (pay_left == 16'd1) || rx_tlast;

    // Stall only where a FIFO push would be lost
    assign rx_tready = !((hdr_end && hdr_full) || (state == S_PAY && pay_full));

    assign hdr_push = hdr_end && xfer && accept;
    assign hdr_item = '{mac: rem_mac, ip: rem_ip, port: rem_port, udp_len: udp_len};

    assign pay_push = (state == S_PAY) && xfer;
    assign pay_item = '{data: rx_tdata, last: pay_last};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_HDR;
            idx   <= '0;
        end else if (xfer) begin
            case (state)
                S_HDR: begin
                    if (rx_tlast) begin
                        idx <= '0;
                    end else if (hdr_end) begin
                        idx   <= '0;
                        state <= accept ? S_PAY : S_DROP;
                    end else begin
                        idx <= idx + 8'd1;
                    end
                end
                S_PAY: begin
                    if (pay_last) begin
                        state <= rx_tlast ? S_HDR : S_DROP;
                    end
                end
                S_DROP: begin
                    if (rx_tlast) begin
                        state <= S_HDR;
                    end
                end
                default: state <= S_HDR;
            endcase
        end
    end

    // Header field capture, byte offsets from the start of the frame
    always_ff @(posedge clk) begin
        if (xfer) begin
            prev_byte <= rx_tdata;
            if (state == S_HDR) begin
                if (idx == 8'd0) fields_ok <= 1'b1;
                if (idx inside {[8'd0:8'd5]}) dst_mac <= {dst_mac[39:0], rx_tdata};
                if (idx inside {[8'd6:8'd11]}) rem_mac <= {rem_mac[39:0], rx_tdata};
                if (idx == 8'd13 && {prev_byte, rx_tdata} != `UDP_ECHO_ETHERTYPE_IPV4) begin
                    fields_ok <= 1'b0;
                end
                // Version 4 with a five word header
                if (idx == 8'd14 && rx_tdata != 8'h45) fields_ok <= 1'b0;
                if (idx == 8'd23 && rx_tdata != `UDP_ECHO_PROTO_UDP) fields_ok <= 1'b0;
                if (idx inside {[8'd26:8'd29]}) rem_ip <= {rem_ip[23:0], rx_tdata};
                if (idx inside {[8'd30:8'd33]}) dst_ip <= {dst_ip[23:0], rx_tdata};
                if (idx inside {[8'd34:8'd35]}) rem_port <= {rem_port[7:0], rx_tdata};
                if (idx == 8'd37 && {prev_byte, rx_tdata} != `UDP_ECHO_PORT) begin
                    fields_ok <= 1'b0;
                end
                if (idx inside {[8'd38:8'd39]}) udp_len <= {udp_len[7:0], rx_tdata};
            end
            if (hdr_end) begin
                pay_left <= udp_len - 16'd8;
            end else if (state == S_PAY) begin
                pay_left <= pay_left - 16'd1;
            end
        end
    end

endmodule

/* design/reply_builder.sv */
/*
 * Transmit side of the echo core. Sends one reply per queued header,
 * UDP checksum zero, IP identification zero and don't-fragment set.
 * leds wraps after 255 replies.
 */
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module reply_builder (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [47:0]                 local_mac,
    input  logic [31:0]                 local_ip,
    input  udp_echo_pkg::echo_hdr_t     hdr_head,
    input  logic                        hdr_empty,
    output logic                        hdr_pop,
    input  udp_echo_pkg::payload_beat_t pay_head,
    input  logic                        pay_empty,
    output logic                        pay_pop,
    output logic [7:0]                  tx_tdata,
    output logic                        tx_tvalid,
    output logic                        tx_tlast,
    input  logic                        tx_tready,
    output logic [7:0]                  leds
);

    typedef enum logic [1:0] {S_IDLE, S_CSUM, S_HDR, S_PAY} state_t;

    localparam int HDR_BITS = 8 * `UDP_ECHO_HDR_BYTES;

    state_t                  state;
    udp_echo_pkg::echo_hdr_t hdr_r;
    logic [7:0]              bidx;
    logic [15:0]             ip_len;
    logic [15:0]             csum;
    logic [19:0]             csum_sum;
    logic [16:0]             csum_fold;
    logic [HDR_BITS-1:0]     hdr_bytes;
    logic                    xfer;

    assign ip_len = hdr_r.udp_len + 16'd20;

    // Identification and checksum words are zero and drop out of the sum
    assign csum_sum = 16'h4500 + ip_len + 16'h4000 +
                      {`UDP_ECHO_TTL, `UDP_ECHO_PROTO_UDP} +
                      local_ip[31:16] + local_ip[15:0] +
                      hdr_r.ip[31:16] + hdr_r.ip[15:0];
    assign csum_fold = csum_sum[15:0] + csum_sum[19:16];

    // Reply header, first byte on the wire in the top bits
    assign hdr_bytes = {
        hdr_r.mac, local_mac, `UDP_ECHO_ETHERTYPE_IPV4,
        8'h45, 8'h00, ip_len, 16'h0000, 16'h4000,
        `UDP_ECHO_TTL, `UDP_ECHO_PROTO_UDP, csum,
        local_ip, hdr_r.ip,
        `UDP_ECHO_PORT, hdr_r.port, hdr_r.udp_len, 16'h0000
    };

    assign xfer = tx_tvalid && tx_tready;

    always_comb begin
        hdr_pop   = 1'b0;
        pay_pop   = 1'b0;
        tx_tvalid = 1'b0;
        tx_tlast  = 1'b0;
        tx_tdata  = hdr_bytes[(HDR_BITS - 8) - 8 * bidx +: 8];
        case (state)
            S_IDLE: hdr_pop = !hdr_empty;
            S_HDR:  tx_tvalid = 1'b1;
            S_PAY: begin
                tx_tvalid = !pay_empty;
                tx_tdata  = pay_head.data;
                tx_tlast  = pay_head.last;
                pay_pop   = !pay_empty && tx_tready;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            bidx  <= '0;
            leds  <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (!hdr_empty) state <= S_CSUM;
                end
                S_CSUM: begin
                    state <= S_HDR;
                    bidx  <= '0;
                end
                S_HDR: begin
                    if (xfer) begin
                        if (bidx == `UDP_ECHO_HDR_BYTES - 8'd1) begin
                            state <= S_PAY;
                        end else begin
                            bidx <= bidx + 8'd1;
                        end
                    end
                end
                S_PAY: begin
                    // Count the reply once its final byte is taken
                    if (xfer && pay_head.last) begin
                        state <= S_IDLE;
                        leds  <= leds + 8'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && !hdr_empty) begin
            hdr_r <= hdr_head;
        end
        // Second fold absorbs the last carry
        if (state == S_CSUM) begin
            csum <= ~(csum_fold[15:0] + {15'd0, csum_fold[16]});
        end
    end

endmodule

/* design/stream_fifo.sv */
/*
 * Synchronous FIFO for any packed item type.
 * DEPTH must be a power of two. Pushes while full and pops while empty
 * are ignored. The head is valid whenever empty is low.
 */
`timescale 1ns/1ps

module stream_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 16
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t head,
    output logic  full,
    output logic  empty
);

    localparam int AW = $clog2(DEPTH);

    item_t       mem [DEPTH];
    // Extra top bit tells a full buffer from an empty one
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign head  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push && !full) begin
            mem[wr_ptr[AW-1:0]] <= push_item;
        end
    end

endmodule

/* design/udp_echo_core.sv */
/*
 * UDP echo core on a single clock with byte-wide valid/ready streams.
 * Station MAC and IP are derived from the device DNA; the IP is fixed
 * to 192.168.1.x. No ARP, so peers need a static entry.
 */
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module udp_echo_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [95:0] dna,
    input  logic [7:0]  rx_tdata,
    input  logic        rx_tvalid,
    input  logic        rx_tlast,
    output logic        rx_tready,
    output logic [7:0]  tx_tdata,
    output logic        tx_tvalid,
    output logic        tx_tlast,
    input  logic        tx_tready,
    output logic [7:0]  leds
);

    logic [47:0]                 local_mac;
    logic [31:0]                 local_ip;
    logic                        hdr_push;
    logic                        hdr_pop;
    logic                        hdr_full;
    logic                        hdr_empty;
    udp_echo_pkg::echo_hdr_t     hdr_item;
    udp_echo_pkg::echo_hdr_t     hdr_head;
    logic                        pay_push;
    logic                        pay_pop;
    logic                        pay_full;
    logic                        pay_empty;
    udp_echo_pkg::payload_beat_t pay_item;
    udp_echo_pkg::payload_beat_t pay_head;

    // Locally administered unicast MAC
    assign local_mac = {dna[47:42], 2'b10, dna[39:0]};
    assign local_ip  = {8'd192, 8'd168, 8'd1, dna[7:0]};

    frame_parser frame_parser_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_tdata  (rx_tdata),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tready (rx_tready),
        .local_mac (local_mac),
        .local_ip  (local_ip),
        .hdr_push  (hdr_push),
        .hdr_item  (hdr_item),
        .hdr_full  (hdr_full),
        .pay_push  (pay_push),
        .pay_item  (pay_item),
        .pay_full  (pay_full)
    );

    stream_fifo #(
        .item_t (udp_echo_pkg::echo_hdr_t),
        .DEPTH  (`UDP_ECHO_HDR_DEPTH)
    ) hdr_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (hdr_push),
        .push_item (hdr_item),
        .pop       (hdr_pop),
        .head      (hdr_head),
        .full      (hdr_full),
        .empty     (hdr_empty)
    );

    stream_fifo #(
        .item_t (udp_echo_pkg::payload_beat_t),
        .DEPTH  (`UDP_ECHO_PAYLOAD_DEPTH)
    ) payload_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (pay_push),
        .push_item (pay_item),
        .pop       (pay_pop),
        .head      (pay_head),
        .full      (pay_full),
        .empty     (pay_empty)
    );

    reply_builder reply_builder_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .local_mac (local_mac),
        .local_ip  (local_ip),
        .hdr_head  (hdr_head),
        .hdr_empty (hdr_empty),
        .hdr_pop   (hdr_pop),
        .pay_head  (pay_head),
        .pay_empty (pay_empty),
        .pay_pop   (pay_pop),
        .tx_tdata  (tx_tdata),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tready (tx_tready),
        .leds      (leds)
    );

endmodule

/* design/udp_echo_pkg.sv */
/*
 * Records passed from the frame parser to the reply builder.
 */
package udp_echo_pkg;

    // Remote peer of an accepted frame
    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
        // UDP length field, header included
        logic [15:0] udp_len;
    } echo_hdr_t;

    // One payload byte with end of payload marker
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } payload_beat_t;

endpackage

/* include/udp_echo_defines.svh */
/*
 * Protocol constants and queue sizes for the UDP echo core.
 * FIFO depths must be powers of two.
 */
`ifndef UDP_ECHO_DEFINES_SVH
`define UDP_ECHO_DEFINES_SVH

// Ethernet and IPv4 field values
`define UDP_ECHO_ETHERTYPE_IPV4 16'h0800
`define UDP_ECHO_PROTO_UDP      8'd17
`define UDP_ECHO_TTL            8'd64

// Local UDP port that gets echoed
`define UDP_ECHO_PORT           16'd7

// Ethernet 14 + IPv4 20 + UDP 8, no IP options
`define UDP_ECHO_HDR_BYTES      8'd42

// Queue sizes
`define UDP_ECHO_PAYLOAD_DEPTH  16
`define UDP_ECHO_HDR_DEPTH      4

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the UDP echo testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_udp_echo -f tb.f \
    || { echo "Build failed"; exit 1; }
./obj_dir/Vtb_udp_echo > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

/* tb.f */
+incdir+include
design/udp_echo_pkg.sv
design/stream_fifo.sv
design/frame_parser.sv
design/reply_builder.sv
design/udp_echo_core.sv
test/tb_udp_echo.sv

/* test/tb_udp_echo.sv */
/*
 * Testbench for the UDP echo core. Frames are sent without FCS and never
 * end before their UDP length. Stimulus comes from seeded LFSRs, so each
 * run sees the same traffic.
 */
`timescale 1ns/1ps
`include "udp_echo_defines.svh"

module tb_udp_echo;

    localparam logic [95:0] DNA     = 96'h5a3c_0f12_3456_789a_bcde_f0c7;
    localparam int          TIMEOUT = 5000;

    logic        clk;
    logic        rst_n;
    logic [7:0]  rx_tdata;
    logic        rx_tvalid;
    logic        rx_tlast;
    logic        rx_tready;
    logic [7:0]  tx_tdata;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;
    logic [7:0]  leds;

    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic [31:0] stim_lfsr;
    logic [31:0] ready_lfsr;
    logic [31:0] ready_bits;
    logic [2:0]  ready_level;
    logic [7:0]  replies_sent;
    logic [7:0]  replies_expected;
    logic [7:0]  frame_q[$];
    logic [7:0]  reply_q[$];
    // Expected tx bytes with tlast in bit 8
    logic [8:0]  exp_q[$];

    udp_echo_core udp_echo_core_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .dna       (DNA),
        .rx_tdata  (rx_tdata),
        .rx_tvalid (rx_tvalid),
        .rx_tlast  (rx_tlast),
        .rx_tready (rx_tready),
        .tx_tdata  (tx_tdata),
        .tx_tvalid (tx_tvalid),
        .tx_tlast  (tx_tlast),
        .tx_tready (tx_tready),
        .leds      (leds)
    );

    always #5 clk = ~clk;

    function automatic void report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_next(s);
            v = {v[30:0], s[0]};
        end
    endtask

    function automatic void add_bytes(input bit to_reply, input logic [63:0] val, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            if (to_reply) begin
                reply_q.push_back(val[8*i +: 8]);
            end else begin
                frame_q.push_back(val[8*i +: 8]);
            end
        end
    endfunction

    // Inverted ones'-complement sum over the 20 byte IP header
    function automatic logic [15:0] ip_checksum(input int first);
        logic [31:0] sum;
        sum = '0;
        for (int i = first; i < first + 20; i += 2) begin
            sum = sum + {16'h0000, reply_q[i], reply_q[i + 1]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    task automatic send_frame(
        input logic [47:0] dst_mac,
        input logic [15:0] ethertype,
        input logic [7:0]  proto,
        input logic [31:0] dst_ip,
        input logic [15:0] dst_port,
        input logic [15:0] udp_len,
        input int          sent_bytes,
        input bit          accepted
    );
        logic [31:0] v;
        logic [47:0] rem_mac;
        logic [31:0] rem_ip;
        logic [15:0] rem_port;
        logic [15:0] csum;
        int          pay_len;
        int          wait_count;
        take_bits(stim_lfsr, 32, v);
        rem_mac = {16'h02aa, v};
        take_bits(stim_lfsr, 32, rem_ip);
        take_bits(stim_lfsr, 16, v);
        rem_port = v[15:0];
        pay_len  = int'(udp_len) - 8;
        frame_q.delete();
        add_bytes(0, dst_mac, 6);
        add_bytes(0, rem_mac, 6);
        add_bytes(0, ethertype, 2);
        add_bytes(0, {8'h45, 8'h00, udp_len + 16'd20, 32'h0000_4000}, 8);
        add_bytes(0, {`UDP_ECHO_TTL, proto, 16'h0000}, 4);
        add_bytes(0, rem_ip, 4);
        add_bytes(0, dst_ip, 4);
        add_bytes(0, {rem_port, dst_port, udp_len, 16'h0000}, 8);
        for (int i = 0; i < sent_bytes; i++) begin
            take_bits(stim_lfsr, 8, v);
            frame_q.push_back(v[7:0]);
        end
        // Reply model with addresses and ports swapped
        if (accepted) begin
            reply_q.delete();
            add_bytes(1, rem_mac, 6);
            add_bytes(1, local_mac, 6);
            add_bytes(1, `UDP_ECHO_ETHERTYPE_IPV4, 2);
            add_bytes(1, {8'h45, 8'h00, udp_len + 16'd20, 32'h0000_4000}, 8);
            add_bytes(1, {`UDP_ECHO_TTL, `UDP_ECHO_PROTO_UDP, 16'h0000}, 4);
            add_bytes(1, local_ip, 4);
            add_bytes(1, rem_ip, 4);
            add_bytes(1, {`UDP_ECHO_PORT, rem_port, udp_len, 16'h0000}, 8);
            csum = ip_checksum(14);
            reply_q[24] = csum[15:8];
            reply_q[25] = csum[7:0];
            foreach (reply_q[i]) begin
                exp_q.push_back({1'b0, reply_q[i]});
            end
            for (int i = 0; i < pay_len; i++) begin
                exp_q.push_back({(i == pay_len - 1), frame_q[42 + i]});
            end
            replies_expected = replies_expected + 8'd1;
        end
        for (int i = 0; i < frame_q.size(); i++) begin
            take_bits(stim_lfsr, 2, v);
            rx_tvalid = 1'b0;
            rx_tlast  = 1'b0;
            for (int k = 0; k < (v[1:0] == 2'd3 ? 2 : 0); k++) begin
                @(negedge clk);
            end
            rx_tvalid = 1'b1;
            rx_tdata  = frame_q[i];
            rx_tlast  = (i == frame_q.size() - 1);
            @(posedge clk);
            wait_count = 0;
            while (!rx_tready && wait_count < TIMEOUT) begin
                wait_count++;
                @(posedge clk);
            end
            if (!rx_tready) begin
                report_failure("Timeout waiting for rx_tready to accept a frame byte");
            end
            @(negedge clk);
        end
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
    endtask

    task automatic wait_replies();
        int wait_count;
        wait_count = 0;
        while (exp_q.size() != 0 && wait_count < 20 * TIMEOUT) begin
            wait_count++;
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            report_failure("Timeout waiting for the expected replies to be sent");
        end
    endtask

    // tx_tready high on ready_level out of four draws
    always @(negedge clk) begin
        take_bits(ready_lfsr, 2, ready_bits);
        tx_tready = (ready_bits[2:0] < ready_level);
    end

    // Compare every transferred reply byte against the model
    always @(posedge clk) begin
        logic [8:0] want;
        if (rst_n && tx_tvalid && tx_tready) begin
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Reply byte 0x%02h was sent with no reply expected",
                                         tx_tdata));
            end else begin
                want = exp_q.pop_front();
                assert (tx_tdata == want[7:0])
                else report_failure($sformatf("** Error: tx_tdata = 0x%02h, expected 0x%02h",
                                              tx_tdata, want[7:0]));
                assert (tx_tlast == want[8])
                else report_failure($sformatf("** Error: tx_tlast = 0x%h, expected 0x%h",
                                              tx_tlast, want[8]));
                if (want[8]) begin
                    replies_sent = replies_sent + 8'd1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_tvalid && !tx_tready) |=> tx_tvalid)
    else report_failure($sformatf("** Error: tx_tvalid = 0x%h, dropped while stalled",
                                  tx_tvalid));

    assert property (@(posedge clk) disable iff (!rst_n)
        (tx_tvalid && !tx_tready) |=> $stable(tx_tdata))
    else report_failure($sformatf("** Error: tx_tdata = 0x%02h, changed while stalled",
                                  tx_tdata));

    assert property (@(posedge clk) disable iff (!rst_n) leds == replies_sent)
    else report_failure($sformatf("** Error: leds = 0x%02h, expected 0x%02h",
                                  leds, replies_sent));

    initial begin
        clk              = 1'b0;
        rst_n            = 1'b0;
        rx_tdata         = 8'h00;
        rx_tvalid        = 1'b0;
        rx_tlast         = 1'b0;
        tx_tready        = 1'b0;
        stim_lfsr        = 32'd82013;
        ready_lfsr       = 32'd82013;
        ready_level      = 3'd4;
        replies_sent     = 8'h00;
        replies_expected = 8'h00;
        // Station addresses from the DNA with MAC bits 41..40 forced to 10
        local_mac = (DNA[47:0] & ~48'h0300_0000_0000) | 48'h0200_0000_0000;
        local_ip  = {8'd192, 8'd168, 8'd1, DNA[7:0]};
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        assert (!tx_tvalid && leds == 8'h00 && rx_tready)
        else report_failure($sformatf("** Error: tx_tvalid = 0x%h leds = 0x%02h rx_tready = 0x%h",
                                      tx_tvalid, leds, rx_tready));

        // Plain echo to the station
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                   `UDP_ECHO_PORT, 16'd28, 20, 1);
        // Filtered frames followed by a valid one
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP,
                   local_ip ^ 32'h1, `UDP_ECHO_PORT, 16'd28, 20, 0);
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                   16'd9, 16'd28, 20, 0);
        send_frame(local_mac, 16'h86dd, `UDP_ECHO_PROTO_UDP, local_ip,
                   `UDP_ECHO_PORT, 16'd28, 20, 0);
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, 8'd6, local_ip,
                   `UDP_ECHO_PORT, 16'd28, 20, 0);
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                   `UDP_ECHO_PORT, 16'd8, 4, 0);
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                   `UDP_ECHO_PORT, 16'd13, 5, 1);
        // Broadcast accepted and other unicast dropped
        send_frame(48'hffff_ffff_ffff, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP,
                   local_ip, `UDP_ECHO_PORT, 16'd16, 8, 1);
        send_frame(local_mac ^ 48'h1, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP,
                   local_ip, `UDP_ECHO_PORT, 16'd16, 8, 0);
        // Ten payload bytes followed by padding
        send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                   `UDP_ECHO_PORT, 16'd18, 25, 1);
        wait_replies();

        // Back-to-back frames with heavy back-pressure in the second half
        for (int n = 0; n < 12; n++) begin
            logic [31:0] len_bits;
            take_bits(stim_lfsr, 5, len_bits);
            ready_level = (n < 6) ? 3'd3 : 3'd1;
            send_frame(local_mac, `UDP_ECHO_ETHERTYPE_IPV4, `UDP_ECHO_PROTO_UDP, local_ip,
                       `UDP_ECHO_PORT, 16'(len_bits[4:0]) + 16'd9,
                       int'(len_bits[4:0]) + 1, 1);
        end
        wait_replies();
        repeat (50) @(negedge clk);

        if (replies_sent != replies_expected) begin
            report_failure($sformatf("** Error: replies_sent = 0x%02h, expected 0x%02h",
                                     replies_sent, replies_expected));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
